//--- Makefile
# Verilator build and run for the command queue testbench

VERILATOR ?= verilator
TOP       ?= cmd_queue_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
verilog/cmd_queue_pkg.sv
verilog/queue_wr_if.sv
verilog/sync_fifo.sv
verilog/write_queue.sv
verilog/cmd_decoder.sv
verilog/cmd_queue_top.sv
verif/cmd_queue_properties.sv
verif/cmd_queue_tb.sv

//--- verif/cmd_queue_properties.sv
// Command queue assertions

`timescale 1ns/1ps

module cmd_queue_properties (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   req_i,
  input logic                   ack_o,
  input logic                   empty_o,
  input logic                   full_o,
  input logic                   reg_rst_i,
  input logic                   reg_rst_we_o,
  input logic                   cmd_valid_o,
  input logic                   cmd_ready_i,
  input cmd_queue_pkg::cmd_op_e cmd_op_o,
  input logic [3:0]             cmd_tid_o,
  input logic [6:0]             cmd_addr_o,
  input logic [15:0]            cmd_len_o,
  input logic [31:0]            cmd_data_o,
  input logic                   cmd_stop_o,
  input logic                   cmd_err_o
);

  // Open CSR request set by req and closed by its ack
  logic req_open_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_open_q <= 1'b0;
    end else if (req_i) begin
      req_open_q <= 1'b1;
    end else if (ack_o) begin
      req_open_q <= 1'b0;
    end
  end

  ack_follows_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> req_open_q) else $error("ack_o without an open request");

  full_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(full_o && empty_o)) else $error("full_o and empty_o high together");

  // Held command must not move under back-pressure
  cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable({cmd_op_o, cmd_tid_o,
    cmd_addr_o, cmd_len_o, cmd_data_o, cmd_stop_o, cmd_err_o}))
    else $error("command changed while stalled");

  rst_we_after_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_rst_we_o |-> $past(reg_rst_i && empty_o))
    else $error("reg_rst_we_o without a completed queue reset");

  // Queue reset clears the FIFO within one cycle
  rst_clears_queue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_rst_i |=> empty_o) else $error("queue not empty after a queue reset");

endmodule

bind cmd_queue_top cmd_queue_properties i_cmd_queue_properties (
  .clk_i, .rst_ni, .req_i, .ack_o, .empty_o, .full_o, .reg_rst_i, .reg_rst_we_o,
  .cmd_valid_o, .cmd_ready_i, .cmd_op_o, .cmd_tid_o, .cmd_addr_o, .cmd_len_o,
  .cmd_data_o, .cmd_stop_o, .cmd_err_o
);

//--- verif/cmd_queue_tb.sv
// Command queue testbench

`timescale 1ns/1ps

module cmd_queue_tb;

  localparam int Depth   = 16;
  localparam int NumRand = 40;
  localparam int NumFill = Depth + 1;
  localparam int NumDesc = NumRand + NumFill + 1 + 3 + 5 + 3;
  localparam int Timeout = 200 * NumDesc + 2000;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   req_i;
  logic [31:0]            data_i;
  logic                   ack_o;
  logic [2:0]             start_thld_i;
  logic [2:0]             ready_thld_i;
  logic [2:0]             ready_thld_o;
  logic                   start_thld_trig_o;
  logic                   ready_thld_trig_o;
  logic                   empty_o;
  logic                   full_o;
  logic                   reg_rst_i;
  logic                   reg_rst_we_o;
  logic                   cmd_valid_o;
  logic                   cmd_ready_i;
  cmd_queue_pkg::cmd_op_e cmd_op_o;
  logic [3:0]             cmd_tid_o;
  logic [6:0]             cmd_addr_o;
  logic [15:0]            cmd_len_o;
  logic [31:0]            cmd_data_o;
  logic                   cmd_stop_o;
  logic                   cmd_err_o;

  integer      seed;
  logic        rand_ready;
  // Expected descriptors with the high dword in 63:32
  logic [63:0] exp_q [$];

  cmd_queue_top #(.Depth(Depth), .ThldIsPow(1), .LimitReadyThld(0)) i_cmd_queue_top (.*);

  always #5 clk_i = ~clk_i;

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else begin
      $display("FAIL at %0t: %s expected %0h got %0h", $time, name, exp, got);
      abort_run();
    end
  endtask

  function automatic logic [63:0] rand_desc();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = $random(seed);
    hi = $random(seed);
    lo[3:2] = 2'b00;
    return {hi, lo};
  endfunction

  // One clock with optional random back-pressure
  task automatic cycle();
    int r;
    @(posedge clk_i);
    if (rand_ready) begin
      r = $random(seed);
      cmd_ready_i <= r[0];
    end
  endtask

  task automatic put_word(input logic [31:0] w);
    cycle();
    req_i  <= 1'b1;
    data_i <= w;
    cycle();
    req_i  <= 1'b0;
  endtask

  task automatic wait_ack();
    @(negedge clk_i);
    while (!ack_o) begin
      cycle();
      @(negedge clk_i);
    end
  endtask

  task automatic send_desc(input logic [63:0] d);
    exp_q.push_back(d);
    put_word(d[31:0]);
    wait_ack();
    put_word(d[63:32]);
    wait_ack();
  endtask

  task automatic drain();
    rand_ready = 1'b0;
    cycle();
    cmd_ready_i <= 1'b1;
    while (exp_q.size() != 0) cycle();
  endtask

  // Sweep codes 0 to 3 at a fixed occupancy
  task automatic check_thresholds(input int occ);
    logic [2:0] prev;
    for (int code = 0; code < 4; code++) begin
      prev = ready_thld_i;
      cycle();
      start_thld_i <= 3'(code);
      ready_thld_i <= 3'(code);
      @(negedge clk_i);
      check_value("ready_thld_o", 64'(prev), 64'(ready_thld_o));
      cycle();
      @(negedge clk_i);
      check_value("ready_thld_o", 64'(code), 64'(ready_thld_o));
      check_value("start_thld_trig_o", 64'(code != 0 && occ >= (1 << (code + 1))),
                  64'(start_thld_trig_o));
      check_value("ready_thld_trig_o", 64'(code != 0 && (Depth - occ) >= (1 << (code + 1))),
                  64'(ready_thld_trig_o));
    end
  endtask

  // Command monitor for the transfer at the next rising edge
  always @(negedge clk_i) begin
    logic [63:0] e;
    if (rst_ni && cmd_valid_o && cmd_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Command delivered while none was expected at %0t", $time);
        abort_run();
      end
      e = exp_q.pop_front();
      check_value("cmd_op_o", (e[3:0] > 4'h3) ? 64'h0 : 64'(e[3:0]), 64'(cmd_op_o));
      check_value("cmd_err_o", 64'(e[3:0] > 4'h3), 64'(cmd_err_o));
      check_value("cmd_tid_o", 64'(e[7:4]), 64'(cmd_tid_o));
      check_value("cmd_addr_o", 64'(e[14:8]), 64'(cmd_addr_o));
      check_value("cmd_stop_o", 64'(e[15]), 64'(cmd_stop_o));
      check_value("cmd_len_o", 64'(e[31:16]), 64'(cmd_len_o));
      check_value("cmd_data_o", 64'(e[63:32]), 64'(cmd_data_o));
    end
  end

  initial begin
    repeat (Timeout) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", Timeout);
    abort_run();
  end

  initial begin
    logic [63:0] d;
    seed = 93984;
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    data_i = '0;
    start_thld_i = '0;
    ready_thld_i = '0;
    reg_rst_i = 1'b0;
    cmd_ready_i = 1'b0;
    rand_ready = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("empty_o", 64'd1, 64'(empty_o));
    check_value("cmd_valid_o", 64'd0, 64'(cmd_valid_o));
    check_value("ack_o", 64'd0, 64'(ack_o));
    check_value("reg_rst_we_o", 64'd0, 64'(reg_rst_we_o));

    // Packing and order under random back-pressure
    rand_ready = 1'b1;
    repeat (NumRand) send_desc(rand_desc());
    drain();

    // Thresholds while filling with the first entry held in the decoder
    cycle();
    cmd_ready_i <= 1'b0;
    for (int k = 1; k <= NumFill; k++) begin
      send_desc(rand_desc());
      check_thresholds(k - 1);
    end
    check_value("full_o", 64'd1, 64'(full_o));

    // High dword ack waits for space
    d = rand_desc();
    exp_q.push_back(d);
    put_word(d[31:0]);
    wait_ack();
    put_word(d[63:32]);
    repeat (5) begin
      @(negedge clk_i);
      check_value("ack_o", 64'd0, 64'(ack_o));
      cycle();
    end
    cmd_ready_i <= 1'b1;
    cycle();
    cmd_ready_i <= 1'b0;
    wait_ack();
    drain();

    // Illegal opcode between legal ones
    rand_ready = 1'b1;
    send_desc(rand_desc());
    d = rand_desc();
    d[3:0] = 4'hF;
    send_desc(d);
    send_desc(rand_desc());
    drain();

    // Queue reset keeps only the held command
    cycle();
    cmd_ready_i <= 1'b0;
    repeat (5) send_desc(rand_desc());
    while (exp_q.size() > 1) exp_q.delete(exp_q.size() - 1);
    cycle();
    reg_rst_i <= 1'b1;
    cycle();
    @(negedge clk_i);
    check_value("empty_o", 64'd1, 64'(empty_o));
    cycle();
    reg_rst_i <= 1'b0;
    @(negedge clk_i);
    check_value("reg_rst_we_o", 64'd1, 64'(reg_rst_we_o));
    cycle();
    @(negedge clk_i);
    check_value("reg_rst_we_o", 64'd0, 64'(reg_rst_we_o));
    check_value("cmd_valid_o", 64'd1, 64'(cmd_valid_o));
    drain();
    rand_ready = 1'b1;
    repeat (3) send_desc(rand_desc());
    drain();

    $display("all tests passed");
    $finish;
  end

endmodule

//--- verilog/cmd_decoder.sv
// Command descriptor decoder

`timescale 1ns/1ps

module cmd_decoder (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // FIFO read side
  input  logic                     rvalid_i,
  output logic                     rready_o,
  input  cmd_queue_pkg::cmd_desc_t rdata_i,

  // Bus engine side
  output logic                     cmd_valid_o,
  input  logic                     cmd_ready_i,
  output cmd_queue_pkg::cmd_op_e   cmd_op_o,
  output logic [3:0]               cmd_tid_o,
  output logic [6:0]               cmd_addr_o,
  output logic [15:0]              cmd_len_o,
  output logic [31:0]              cmd_data_o,
  output logic                     cmd_stop_o,
  output logic                     cmd_err_o
);

  logic pop;
  logic op_legal;

  // Refill when empty or draining this cycle
  assign rready_o = ~cmd_valid_o | cmd_ready_i;
  assign pop      = rvalid_i & rready_o;

  always_comb begin
    op_legal = 1'b0;
    case (rdata_i.opcode)
      cmd_queue_pkg::OP_WRITE,
      cmd_queue_pkg::OP_READ,
      cmd_queue_pkg::OP_ADDR_ASSIGN,
      cmd_queue_pkg::OP_CCC: op_legal = 1'b1;
      default:               op_legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_valid_o <= 1'b0;
    end else if (pop) begin
      cmd_valid_o <= 1'b1;
    end else if (cmd_ready_i) begin
      cmd_valid_o <= 1'b0;
    end
  end

  // Held command fields
  always_ff @(posedge clk_i) begin
    if (pop) begin
      // Illegal codes go out as a flagged write
      cmd_op_o   <= op_legal ? cmd_queue_pkg::cmd_op_e'(rdata_i.opcode)
                             : cmd_queue_pkg::OP_WRITE;
      cmd_err_o  <= ~op_legal;
      cmd_tid_o  <= rdata_i.tid;
      cmd_addr_o <= rdata_i.tgt_addr;
      cmd_len_o  <= rdata_i.data_len;
      cmd_data_o <= rdata_i.imm_data;
      cmd_stop_o <= rdata_i.stop;
    end
  end

endmodule

//--- verilog/cmd_queue_pkg.sv
// Command queue shared definitions

package cmd_queue_pkg;

  // Bus widths
  localparam int unsigned csr_width_p  = 32;
  localparam int unsigned desc_width_p = 64;
  localparam int unsigned thld_width_p = 3;

  // Command opcodes the decoder accepts
  typedef enum logic [3:0] {
    OP_WRITE       = 4'h0,
    OP_READ        = 4'h1,
    OP_ADDR_ASSIGN = 4'h2,
    OP_CCC         = 4'h3
  } cmd_op_e;

  // Descriptor layout with the high dword first
  // Opcode kept as raw bits so illegal codes survive the queue
  typedef struct packed {
    logic [31:0] imm_data;
    logic [15:0] data_len;
    logic        stop;
    logic [6:0]  tgt_addr;
    logic [3:0]  tid;
    logic [3:0]  opcode;
  } cmd_desc_t;

endpackage

//--- verilog/cmd_queue_top.sv
// Command queue top level

`timescale 1ns/1ps

module cmd_queue_top #(
  parameter int unsigned Depth          = 16,
  parameter bit          ThldIsPow      = 1,
  parameter bit          LimitReadyThld = 0
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,

  // CSR side
  input  logic                                   req_i,
  input  logic [cmd_queue_pkg::csr_width_p-1:0]  data_i,
  output logic                                   ack_o,
  input  logic [cmd_queue_pkg::thld_width_p-1:0] start_thld_i,
  input  logic [cmd_queue_pkg::thld_width_p-1:0] ready_thld_i,
  output logic [cmd_queue_pkg::thld_width_p-1:0] ready_thld_o,
  output logic                                   start_thld_trig_o,
  output logic                                   ready_thld_trig_o,
  output logic                                   empty_o,
  output logic                                   full_o,
  input  logic                                   reg_rst_i,
  output logic                                   reg_rst_we_o,

  // Command side
  output logic                                   cmd_valid_o,
  input  logic                                   cmd_ready_i,
  output cmd_queue_pkg::cmd_op_e                 cmd_op_o,
  output logic [3:0]                             cmd_tid_o,
  output logic [6:0]                             cmd_addr_o,
  output logic [15:0]                            cmd_len_o,
  output logic [31:0]                            cmd_data_o,
  output logic                                   cmd_stop_o,
  output logic                                   cmd_err_o
);

  logic                     rvalid;
  logic                     rready;
  cmd_queue_pkg::cmd_desc_t rdata;

  queue_wr_if #(.Depth(Depth)) wr_if ();

  write_queue #(
    .Depth          (Depth),
    .ThldIsPow      (ThldIsPow),
    .LimitReadyThld (LimitReadyThld)
  ) i_write_queue (
    .clk_i, .rst_ni, .req_i, .data_i, .ack_o,
    .start_thld_i, .ready_thld_i, .ready_thld_o,
    .start_thld_trig_o, .ready_thld_trig_o, .empty_o,
    .reg_rst_i, .reg_rst_we_o,
    .wr (wr_if.producer)
  );

  sync_fifo #(.Depth(Depth)) i_sync_fifo (
    .clk_i, .rst_ni,
    .wr       (wr_if.fifo),
    .rvalid_o (rvalid),
    .rready_i (rready),
    .rdata_o  (rdata),
    .full_o
  );

  cmd_decoder i_cmd_decoder (
    .clk_i, .rst_ni,
    .rvalid_i (rvalid),
    .rready_o (rready),
    .rdata_i  (rdata),
    .cmd_valid_o, .cmd_ready_i, .cmd_op_o, .cmd_tid_o, .cmd_addr_o,
    .cmd_len_o, .cmd_data_o, .cmd_stop_o, .cmd_err_o
  );

endmodule

//--- verilog/queue_wr_if.sv
// Write queue to FIFO link

`timescale 1ns/1ps

interface queue_wr_if #(
  parameter int unsigned Depth = 16
) ();

  localparam int unsigned DepthWidth = $clog2(Depth + 1);

  logic                     wvalid;
  logic                     wready;
  cmd_queue_pkg::cmd_desc_t wdata;
  logic                     clr;
  logic [DepthWidth-1:0]    depth;

  modport producer (
    output wvalid, wdata, clr,
    input  wready, depth
  );

  modport fifo (
    input  wvalid, wdata, clr,
    output wready, depth
  );

endinterface

//--- verilog/sync_fifo.sv
// Synchronous descriptor FIFO

`timescale 1ns/1ps

module sync_fifo #(
  parameter int unsigned Depth = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  queue_wr_if.fifo                 wr,

  output logic                     rvalid_o,
  input  logic                     rready_i,
  output cmd_queue_pkg::cmd_desc_t rdata_o,

  output logic                     full_o
);

  localparam int unsigned PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned DepthWidth = $clog2(Depth + 1);

  cmd_queue_pkg::cmd_desc_t mem [Depth];

  logic [PtrWidth-1:0]   wptr_q;
  logic [PtrWidth-1:0]   rptr_q;
  logic [DepthWidth-1:0] count_q;
  logic                  push;
  logic                  pop;

  assign full_o    = (count_q == DepthWidth'(Depth));
  assign rvalid_o  = (count_q != '0);
  assign wr.wready = ~full_o;
  assign wr.depth  = count_q;
  assign rdata_o   = mem[rptr_q];

  // Clear wins over both sides
  assign push = wr.wvalid & wr.wready & ~wr.clr;
  assign pop  = rvalid_o & rready_i & ~wr.clr;

  // Pointer advance with wrap for any depth
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else if (wr.clr) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= next_ptr(wptr_q);
      end
      if (pop) begin
        rptr_q <= next_ptr(rptr_q);
      end
      // Simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wr.wdata;
    end
  end

endmodule

//--- verilog/write_queue.sv
// Command write queue

`timescale 1ns/1ps

module write_queue #(
  parameter int unsigned Depth          = 16,
  parameter bit          ThldIsPow      = 1,
  parameter bit          LimitReadyThld = 0
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,

  // CSR word access
  input  logic                                  req_i,
  input  logic [cmd_queue_pkg::csr_width_p-1:0] data_i,
  output logic                                  ack_o,

  // Thresholds
  input  logic [cmd_queue_pkg::thld_width_p-1:0] start_thld_i,
  input  logic [cmd_queue_pkg::thld_width_p-1:0] ready_thld_i,
  output logic [cmd_queue_pkg::thld_width_p-1:0] ready_thld_o,
  output logic                                   start_thld_trig_o,
  output logic                                   ready_thld_trig_o,
  output logic                                   empty_o,

  // Software queue reset
  input  logic                                  reg_rst_i,
  output logic                                  reg_rst_we_o,

  queue_wr_if.producer                          wr
);

  localparam int unsigned DepthWidth = $clog2(Depth + 1);
  localparam int unsigned ThldW      = cmd_queue_pkg::thld_width_p;
  localparam int unsigned CsrW       = cmd_queue_pkg::csr_width_p;

  // Largest code that still fits the queue
  localparam logic [ThldW-1:0] PowClampCode = ThldW'($clog2(Depth) - 1);
  localparam logic [ThldW-1:0] LinClampCode = ThldW'(Depth - 1);

  logic                  dword_idx_q;
  logic                  wvalid_q;
  logic [CsrW-1:0]       lo_dword_q;
  logic [CsrW-1:0]       hi_dword_q;
  logic [DepthWidth-1:0] empty_entries;
  logic                  write_done;

  // Entry count for a threshold code
  function automatic int unsigned thld_entries(input logic [ThldW-1:0] code);
    if (ThldIsPow) begin
      return 32'd1 << (int'(code) + 1);
    end
    return int'(code);
  endfunction

  assign wr.wvalid  = wvalid_q;
  assign wr.wdata   = cmd_queue_pkg::cmd_desc_t'({hi_dword_q, lo_dword_q});
  assign wr.clr     = reg_rst_i;
  assign write_done = wvalid_q & wr.wready;

  // A zero threshold code disables its trigger
  always_comb begin
    empty_o       = (wr.depth == '0);
    empty_entries = DepthWidth'(Depth) - wr.depth;
    start_thld_trig_o = (start_thld_i != '0) &&
                        (int'(wr.depth) >= thld_entries(start_thld_i));
    ready_thld_trig_o = (ready_thld_o != '0) &&
                        (int'(empty_entries) >= thld_entries(ready_thld_o));
  end

  // Registered ready threshold
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_thld_o <= '0;
    end else if (!LimitReadyThld) begin
      ready_thld_o <= ready_thld_i;
    end else if (ThldIsPow) begin
      ready_thld_o <= (thld_entries(ready_thld_i) >= Depth) ? PowClampCode : ready_thld_i;
    end else begin
      ready_thld_o <= (int'(ready_thld_i) >= Depth) ? LinClampCode : ready_thld_i;
    end
  end

  // Reset is confirmed once the queue reads empty
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reg_rst_we_o <= 1'b0;
    end else begin
      reg_rst_we_o <= reg_rst_i & empty_o;
    end
  end

  // Dword sequencing and handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dword_idx_q <= 1'b0;
      wvalid_q    <= 1'b0;
      ack_o       <= 1'b0;
    end else begin
      ack_o <= 1'b0;
      if (req_i) begin
        if (!dword_idx_q) begin
          // Low half acked right away
          dword_idx_q <= 1'b1;
          ack_o       <= 1'b1;
        end else begin
          wvalid_q <= 1'b1;
        end
      end
      // High half acked once the FIFO took the entry
      if (write_done) begin
        wvalid_q    <= 1'b0;
        dword_idx_q <= 1'b0;
        ack_o       <= 1'b1;
      end
    end
  end

  // Entry halves
  always_ff @(posedge clk_i) begin
    if (req_i && !dword_idx_q) begin
      lo_dword_q <= data_i;
    end
    if (req_i && dword_idx_q) begin
      hi_dword_q <= data_i;
    end
  end

endmodule
